//--- verilog/issue_pkg.sv
/* Widths, entry counts and encodings shared by the issue slice.
   Tag 0 is reserved to mean "value present", so live ROB tags are 1 to 15. */
`default_nettype none

package issue_pkg;

    localparam int xlen             = 32;
    localparam int rob_tag_width    = 4;
    localparam int num_alu_entries  = 2; // Entries 0..1
    localparam int num_mult_entries = 2; // Entries 2..3
    localparam int num_rs           = num_alu_entries + num_mult_entries;
    localparam int mult_stages      = 3;

    typedef logic [rob_tag_width-1:0] rob_tag_t;
    typedef logic [$clog2(num_rs)-1:0] rs_idx_t; // Station entry index

    // Unit class picked at decode, fu_none blocks dispatch
    typedef enum logic [1:0] {
        fu_none,
        fu_alu,
        fu_mult
    } fu_class_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_mul // Only ever routed to the multiplier
    } alu_op_e;

    // RV32 major opcodes that are decoded here
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011, // R-type
        opc_op_imm = 7'b0010011  // I-type ALU
    } opcode_e;

    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000; // SUB
    localparam logic [6:0] funct7_mext = 7'b0000001; // M extension

endpackage

`default_nettype wire

//--- verilog/rs_issue_if.sv
/* One issued operation from the station to a unit.
   No ready: the station only raises issue_valid while the unit holds accept high. */
`timescale 1ns/1ps
`default_nettype none

interface rs_issue_if;
    import issue_pkg::*;

    logic            issue_valid;
    alu_op_e         alu_op;
    logic [xlen-1:0] opa;
    logic [xlen-1:0] opb;
    rob_tag_t        rob_tag;
    logic            accept; // Unit can take an operation this cycle

    modport station (
        output issue_valid, alu_op, opa, opb, rob_tag,
        input  accept
    );

    modport unit (
        input  issue_valid, alu_op, opa, opb, rob_tag,
        output accept
    );

endinterface

`default_nettype wire

//--- verilog/fu_result_if.sv
/* Unit result toward the CDB arbiter, valid/ready.
   Valid and data stay stable until ready is seen. */
`timescale 1ns/1ps
`default_nettype none

interface fu_result_if;
    import issue_pkg::*;

    logic            valid;
    logic            ready;
    rob_tag_t        rob_tag;
    logic [xlen-1:0] value;

    modport source (output valid, rob_tag, value, input ready);
    modport sink   (input valid, rob_tag, value, output ready);

endinterface

`default_nettype wire

//--- verilog/inst_decode.sv
/* Decodes ADD, SUB, AND, OR, XOR, SLT, ADDI and MUL only.
   Everything else, loads and branches included, comes out as fu_none. */
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input  logic [issue_pkg::xlen-1:0] inst,
    output issue_pkg::fu_class_e       fu_class,
    output issue_pkg::alu_op_e         alu_op,
    output logic                       use_imm,
    output logic [issue_pkg::xlen-1:0] imm
);
    import issue_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign imm    = {{(xlen-12){inst[31]}}, inst[31:20]}; // I-type, sign extended

    always_comb begin
        fu_class = fu_none; // Refused unless matched below
        alu_op   = alu_add;
        use_imm  = 1'b0;
        case (inst[6:0])
            opc_op: begin
                if (funct7 == funct7_mext && funct3 == 3'b000) begin
                    fu_class = fu_mult;
                    alu_op   = alu_mul;
                end else if (funct7 == funct7_alt && funct3 == 3'b000) begin
                    fu_class = fu_alu;
                    alu_op   = alu_sub;
                end else if (funct7 == funct7_base) begin
                    fu_class = fu_alu;
                    case (funct3)
                        3'b000:  alu_op = alu_add;
                        3'b010:  alu_op = alu_slt;
                        3'b100:  alu_op = alu_xor;
                        3'b110:  alu_op = alu_or;
                        3'b111:  alu_op = alu_and;
                        default: fu_class = fu_none; // Shifts, SLTU
                    endcase
                end
            end
            opc_op_imm: begin
                if (funct3 == 3'b000) begin // ADDI only
                    fu_class = fu_alu;
                    use_imm  = 1'b1;
                end
            end
            default: fu_class = fu_none;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/rs.sv
/* Fixed-class station where the low entries feed the ALU and the rest the multiplier.
   An entry stays busy after issue until the CDB broadcasts its own ROB tag. */
`timescale 1ns/1ps
`default_nettype none

module rs (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       squash,
    input  logic                       dispatch_valid,
    input  issue_pkg::fu_class_e       fu_class,
    input  issue_pkg::alu_op_e         alu_op,
    input  logic                       use_imm,
    input  logic [issue_pkg::xlen-1:0] imm,
    input  issue_pkg::rob_tag_t        dispatch_rob_tag,
    input  issue_pkg::rob_tag_t        src1_tag,
    input  logic [issue_pkg::xlen-1:0] src1_value,
    input  issue_pkg::rob_tag_t        src2_tag,
    input  logic [issue_pkg::xlen-1:0] src2_value,
    input  logic                       cdb_valid,
    input  issue_pkg::rob_tag_t        cdb_rob_tag,
    input  logic [issue_pkg::xlen-1:0] cdb_value,
    output logic                       dispatch_ready,
    rs_issue_if.station                alu_issue,
    rs_issue_if.station                mult_issue
);
    import issue_pkg::*;

    logic [num_rs-1:0] busy;
    logic [num_rs-1:0] issued;
    rob_tag_t          entry_tag [num_rs]; // Destination ROB tag
    alu_op_e           entry_op  [num_rs];
    rob_tag_t          t1        [num_rs]; // 0 once the operand is held
    rob_tag_t          t2        [num_rs];
    logic [xlen-1:0]   v1        [num_rs];
    logic [xlen-1:0]   v2        [num_rs];

    logic            alloc_fire;
    rs_idx_t         alloc_idx;
    logic            alu_found, mult_found;
    rs_idx_t         alu_sel, mult_sel;
    rob_tag_t        t1_init, t2_init;
    logic [xlen-1:0] v1_init, v2_init;
    logic            dup_tag;
    logic            early_free;

    function automatic fu_class_e entry_class(input int idx);
        return (idx < num_alu_entries) ? fu_alu : fu_mult;
    endfunction

    // Lowest free entry of the decoded class; descending loop so lowest wins
    always_comb begin
        dispatch_ready = 1'b0;
        alloc_idx      = '0;
        for (int i = num_rs - 1; i >= 0; i--) begin
            if (!busy[i] && entry_class(i) == fu_class) begin
                dispatch_ready = 1'b1;
                alloc_idx      = rs_idx_t'(i);
            end
        end
    end

    assign alloc_fire = dispatch_valid && dispatch_ready;

    // Operand capture at dispatch including a same-edge CDB hit
    always_comb begin
        t1_init = src1_tag;
        v1_init = '0;
        if (src1_tag == '0) begin
            v1_init = src1_value;
        end else if (cdb_valid && cdb_rob_tag == src1_tag) begin
            t1_init = '0;
            v1_init = cdb_value;
        end
        t2_init = src2_tag;
        v2_init = '0;
        if (use_imm) begin // ADDI ignores rs2
            t2_init = '0;
            v2_init = imm;
        end else if (src2_tag == '0) begin
            v2_init = src2_value;
        end else if (cdb_valid && cdb_rob_tag == src2_tag) begin
            t2_init = '0;
            v2_init = cdb_value;
        end
    end

    // Per-class issue of the lowest ready and unissued entry
    always_comb begin
        alu_found  = 1'b0;
        mult_found = 1'b0;
        alu_sel    = '0;
        mult_sel   = '0;
        for (int i = num_rs - 1; i >= 0; i--) begin
            if (busy[i] && !issued[i] && t1[i] == '0 && t2[i] == '0) begin
                if (entry_class(i) == fu_alu) begin
                    alu_found = 1'b1;
                    alu_sel   = rs_idx_t'(i);
                end else begin
                    mult_found = 1'b1;
                    mult_sel   = rs_idx_t'(i);
                end
            end
        end
    end

    assign alu_issue.issue_valid  = alu_found && alu_issue.accept;
    assign alu_issue.alu_op       = entry_op[alu_sel];
    assign alu_issue.opa          = v1[alu_sel];
    assign alu_issue.opb          = v2[alu_sel];
    assign alu_issue.rob_tag      = entry_tag[alu_sel];
    assign mult_issue.issue_valid = mult_found && mult_issue.accept;
    assign mult_issue.alu_op      = entry_op[mult_sel];
    assign mult_issue.opa         = v1[mult_sel];
    assign mult_issue.opb         = v2[mult_sel];
    assign mult_issue.rob_tag     = entry_tag[mult_sel];

    // Entry state
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy   <= '0;
            issued <= '0;
        end else if (squash) begin
            busy   <= '0; // Drop everything in flight
            issued <= '0;
        end else begin
            for (int i = 0; i < num_rs; i++) begin
                if (cdb_valid && busy[i] && entry_tag[i] == cdb_rob_tag) begin
                    busy[i]   <= 1'b0; // Own result broadcast
                    issued[i] <= 1'b0;
                end
            end
            if (alloc_fire) begin
                busy[alloc_idx]   <= 1'b1;
                issued[alloc_idx] <= 1'b0;
            end
            if (alu_issue.issue_valid) issued[alu_sel] <= 1'b1;
            if (mult_issue.issue_valid) issued[mult_sel] <= 1'b1;
        end
    end

    // CDB wakeup of operands with the allocation write last
    always_ff @(posedge clock) begin
        for (int i = 0; i < num_rs; i++) begin
            if (cdb_valid && t1[i] != '0 && t1[i] == cdb_rob_tag) begin
                t1[i] <= '0;
                v1[i] <= cdb_value;
            end
            if (cdb_valid && t2[i] != '0 && t2[i] == cdb_rob_tag) begin
                t2[i] <= '0;
                v2[i] <= cdb_value;
            end
        end
        if (alloc_fire) begin
            entry_tag[alloc_idx] <= dispatch_rob_tag;
            entry_op[alloc_idx]  <= alu_op;
            t1[alloc_idx]        <= t1_init;
            t2[alloc_idx]        <= t2_init;
            v1[alloc_idx]        <= v1_init;
            v2[alloc_idx]        <= v2_init;
        end
    end

    always_comb begin
        dup_tag = 1'b0;
        for (int i = 0; i < num_rs; i++)
            for (int j = i + 1; j < num_rs; j++)
                if (busy[i] && busy[j] && entry_tag[i] == entry_tag[j]) dup_tag = 1'b1;
    end

    // Broadcast of a busy entry's tag before that entry went to a unit
    always_comb begin
        early_free = 1'b0;
        for (int i = 0; i < num_rs; i++)
            if (cdb_valid && busy[i] && !issued[i] && entry_tag[i] == cdb_rob_tag)
                early_free = 1'b1;
    end

    // Only an issued entry may see its own tag on the CDB
    free_after_issue: assert property (@(posedge clock) disable iff (reset) !early_free);

    unique_busy_tags: assert property (@(posedge clock) disable iff (reset) !dup_tag);

endmodule

`default_nettype wire

//--- verilog/alu_unit.sv
/* Single-cycle ALU with one result register.
   A refused result holds and accept stays low until the arbiter takes it. */
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  logic        clock,
    input  logic        reset,
    input  logic        squash,
    rs_issue_if.unit    issue,
    fu_result_if.source result
);
    import issue_pkg::*;

    logic            res_valid;
    rob_tag_t        res_tag;
    logic [xlen-1:0] res_value;
    logic [xlen-1:0] alu_out;

    always_comb begin
        case (issue.alu_op)
            alu_add: alu_out = issue.opa + issue.opb;
            alu_sub: alu_out = issue.opa - issue.opb;
            alu_and: alu_out = issue.opa & issue.opb;
            alu_or:  alu_out = issue.opa | issue.opb;
            alu_xor: alu_out = issue.opa ^ issue.opb;
            alu_slt: alu_out = {{(xlen-1){1'b0}}, $signed(issue.opa) < $signed(issue.opb)};
            default: alu_out = '0; // MUL never reaches here
        endcase
    end

    assign issue.accept = !res_valid || result.ready; // Empty or draining

    always_ff @(posedge clock or posedge reset) begin
        if (reset)                   res_valid <= 1'b0;
        else if (squash)             res_valid <= 1'b0;
        else if (issue.issue_valid)  res_valid <= 1'b1;
        else if (result.ready)       res_valid <= 1'b0; // Taken onto the CDB
    end

    always_ff @(posedge clock) begin
        if (issue.issue_valid) begin
            res_tag   <= issue.rob_tag;
            res_value <= alu_out;
        end
    end

    assign result.valid   = res_valid;
    assign result.rob_tag = res_tag;
    assign result.value   = res_value;

endmodule

`default_nettype wire

//--- verilog/mult_pipe.sv
/* Three-stage multiplier, low 32 bits of the product only.
   Never stalls, so it relies on always winning the CDB. */
`timescale 1ns/1ps
`default_nettype none

module mult_pipe (
    input  logic        clock,
    input  logic        reset,
    input  logic        squash,
    rs_issue_if.unit    issue,
    fu_result_if.source result
);
    import issue_pkg::*;

    logic [mult_stages-1:0] stage_valid;
    rob_tag_t               stage_tag [mult_stages];
    logic [xlen-1:0]        pp_low;   // Stage 1, low halves product
    logic [xlen/2-1:0]      pp_cross; // Stage 1, cross terms mod 2^16
    logic [xlen-1:0]        sum_s2;   // Stage 2
    logic [xlen-1:0]        prod_s3;  // Stage 3

    assign issue.accept = 1'b1;

    always_ff @(posedge clock or posedge reset) begin
        if (reset)       stage_valid <= '0;
        else if (squash) stage_valid <= '0;
        else             stage_valid <= {stage_valid[mult_stages-2:0], issue.issue_valid};
    end

    always_ff @(posedge clock) begin
        stage_tag[0] <= issue.rob_tag;
        for (int i = 1; i < mult_stages; i++) stage_tag[i] <= stage_tag[i-1];
        pp_low   <= issue.opa[xlen/2-1:0] * issue.opb[xlen/2-1:0];
        pp_cross <= issue.opa[xlen/2-1:0] * issue.opb[xlen-1:xlen/2]
                  + issue.opa[xlen-1:xlen/2] * issue.opb[xlen/2-1:0];
        sum_s2   <= pp_low + {pp_cross, {(xlen/2){1'b0}}}; // High x high drops out
        prod_s3  <= sum_s2;
    end

    assign result.valid   = stage_valid[mult_stages-1];
    assign result.rob_tag = stage_tag[mult_stages-1];
    assign result.value   = prod_s3;

    // Arbiter must never back-pressure the pipe
    mult_never_refused: assert property (@(posedge clock) disable iff (reset)
        result.valid |-> result.ready);

endmodule

`default_nettype wire

//--- verilog/cdb_arbiter.sv
/* Fixed priority onto the single CDB with the multiplier over the ALU.
   Purely combinational with no clock. */
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
    fu_result_if.sink                  alu_result,
    fu_result_if.sink                  mult_result,
    output logic                       cdb_valid,
    output issue_pkg::rob_tag_t        cdb_rob_tag,
    output logic [issue_pkg::xlen-1:0] cdb_value
);
    import issue_pkg::*;

    assign mult_result.ready = 1'b1;
    assign alu_result.ready  = !mult_result.valid; // ALU holds behind MUL

    assign cdb_valid   = mult_result.valid || alu_result.valid;
    assign cdb_rob_tag = mult_result.valid ? mult_result.rob_tag : alu_result.rob_tag;
    assign cdb_value   = mult_result.valid ? mult_result.value : alu_result.value;

endmodule

`default_nettype wire

//--- verilog/issue_core_top.sv
/* Issue and execute slice, ROB and map table sit outside.
   src tag 0 means the value port already holds the operand. */
`timescale 1ns/1ps
`default_nettype none

module issue_core_top (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       squash,
    input  logic                       dispatch_valid,
    input  logic [issue_pkg::xlen-1:0] dispatch_inst,
    input  issue_pkg::rob_tag_t        dispatch_rob_tag,
    input  issue_pkg::rob_tag_t        src1_tag,
    input  logic [issue_pkg::xlen-1:0] src1_value,
    input  issue_pkg::rob_tag_t        src2_tag,
    input  logic [issue_pkg::xlen-1:0] src2_value,
    output logic                       dispatch_ready,
    output logic                       cdb_valid,
    output issue_pkg::rob_tag_t        cdb_rob_tag,
    output logic [issue_pkg::xlen-1:0] cdb_value
);
    import issue_pkg::*;

    fu_class_e       fu_class;
    alu_op_e         alu_op;
    logic            use_imm;
    logic [xlen-1:0] imm;

    rs_issue_if  alu_issue ();
    rs_issue_if  mult_issue ();
    fu_result_if alu_result ();
    fu_result_if mult_result ();

    inst_decode u_decode (
        .inst     (dispatch_inst),
        .fu_class (fu_class),
        .alu_op   (alu_op),
        .use_imm  (use_imm),
        .imm      (imm)
    );

    rs u_rs (
        .clock            (clock),
        .reset            (reset),
        .squash           (squash),
        .dispatch_valid   (dispatch_valid),
        .fu_class         (fu_class),
        .alu_op           (alu_op),
        .use_imm          (use_imm),
        .imm              (imm),
        .dispatch_rob_tag (dispatch_rob_tag),
        .src1_tag         (src1_tag),
        .src1_value       (src1_value),
        .src2_tag         (src2_tag),
        .src2_value       (src2_value),
        .cdb_valid        (cdb_valid), // Wakeup and free
        .cdb_rob_tag      (cdb_rob_tag),
        .cdb_value        (cdb_value),
        .dispatch_ready   (dispatch_ready),
        .alu_issue        (alu_issue.station),
        .mult_issue       (mult_issue.station)
    );

    alu_unit u_alu (
        .clock  (clock),
        .reset  (reset),
        .squash (squash),
        .issue  (alu_issue.unit),
        .result (alu_result.source)
    );

    mult_pipe u_mult (
        .clock  (clock),
        .reset  (reset),
        .squash (squash),
        .issue  (mult_issue.unit),
        .result (mult_result.source)
    );

    cdb_arbiter u_arb (
        .alu_result  (alu_result.sink),
        .mult_result (mult_result.sink),
        .cdb_valid   (cdb_valid),
        .cdb_rob_tag (cdb_rob_tag),
        .cdb_value   (cdb_value)
    );

endmodule

`default_nettype wire

//--- verification/issue_core_tb.sv
/* Directed tests for the issue slice, results checked by ROB tag against an RV32 model.
   ADDI takes its immediate from the low 12 bits of the second operand argument. */
`timescale 1ns/1ps
`default_nettype none

module issue_core_tb;
    import issue_pkg::*;

    localparam int clock_period    = 20;
    localparam int num_tests       = 6;
    localparam int cycles_per_test = 40;
    localparam int num_tags        = 2 ** rob_tag_width;

    typedef enum int {op_add, op_sub, op_and, op_or, op_xor, op_slt, op_addi, op_mul} tb_op_e;

    logic            clock;
    logic            reset;
    logic            squash;
    logic            dispatch_valid;
    logic [xlen-1:0] dispatch_inst;
    rob_tag_t        dispatch_rob_tag;
    rob_tag_t        src1_tag, src2_tag;
    logic [xlen-1:0] src1_value, src2_value;
    logic            dispatch_ready;
    logic            cdb_valid;
    rob_tag_t        cdb_rob_tag;
    logic [xlen-1:0] cdb_value;

    // Scoreboard, one slot per ROB tag
    logic [num_tags-1:0] exp_pending = '0;
    logic [xlen-1:0]     exp_value [num_tags];
    int                  arrival   [num_tags]; // Cycle of last broadcast
    int cycle      = 0;
    int checks     = 0;
    int errors     = 0;
    int broadcasts = 0;
    int mark;
    int seed;

    issue_core_top i_dut (
        .clock            (clock),
        .reset            (reset),
        .squash           (squash),
        .dispatch_valid   (dispatch_valid),
        .dispatch_inst    (dispatch_inst),
        .dispatch_rob_tag (dispatch_rob_tag),
        .src1_tag         (src1_tag),
        .src1_value       (src1_value),
        .src2_tag         (src2_tag),
        .src2_value       (src2_value),
        .dispatch_ready   (dispatch_ready),
        .cdb_valid        (cdb_valid),
        .cdb_rob_tag      (cdb_rob_tag),
        .cdb_value        (cdb_value)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    always @(posedge clock) cycle++;

    task automatic require(input bit cond, input string msg);
        checks++;
        assert (cond) else begin
            errors++;
            $display("ERROR at %0t: %s", $time, msg);
        end
    endtask

    task automatic compare_value(input string name, input logic [xlen-1:0] got,
                                 input logic [xlen-1:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED at %0t: %s got %h, expected %h", $time, name, got, exp);
        end
    endtask

    // RV32 semantics, low product word for MUL
    function automatic logic [xlen-1:0] model(input tb_op_e op, input logic [xlen-1:0] a,
                                              input logic [xlen-1:0] b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_addi: return a + {{20{b[11]}}, b[11:0]};
            default: return a * b;
        endcase
    endfunction

    // rd x1, rs1 x2, rs2 x3; register numbers mean nothing to the slice
    function automatic logic [xlen-1:0] encode(input tb_op_e op, input logic [11:0] imm);
        case (op)
            op_add:  return {7'b0000000, 5'd3, 5'd2, 3'b000, 5'd1, 7'b0110011};
            op_sub:  return {7'b0100000, 5'd3, 5'd2, 3'b000, 5'd1, 7'b0110011};
            op_and:  return {7'b0000000, 5'd3, 5'd2, 3'b111, 5'd1, 7'b0110011};
            op_or:   return {7'b0000000, 5'd3, 5'd2, 3'b110, 5'd1, 7'b0110011};
            op_xor:  return {7'b0000000, 5'd3, 5'd2, 3'b100, 5'd1, 7'b0110011};
            op_slt:  return {7'b0000000, 5'd3, 5'd2, 3'b010, 5'd1, 7'b0110011};
            op_mul:  return {7'b0000001, 5'd3, 5'd2, 3'b000, 5'd1, 7'b0110011};
            default: return {imm, 5'd2, 3'b000, 5'd1, 7'b0010011}; // ADDI
        endcase
    endfunction

    task automatic expect_result(input rob_tag_t tag, input logic [xlen-1:0] value);
        require(!exp_pending[tag], $sformatf("tag %0d reused while still outstanding", tag));
        exp_pending[tag] = 1'b1;
        exp_value[tag]   = value;
    endtask

    // Returns 2 ns after the accepting edge; waiting operands get junk on the value port
    task automatic dispatch(input tb_op_e op, input rob_tag_t tag, input rob_tag_t t1,
                            input logic [xlen-1:0] a, input rob_tag_t t2,
                            input logic [xlen-1:0] b, input bit tracked);
        int waited;
        bit accepted;
        dispatch_valid   = 1'b1;
        dispatch_inst    = encode(op, b[11:0]);
        dispatch_rob_tag = tag;
        src1_tag         = t1;
        src1_value       = (t1 == 0) ? a : 32'hdead_beef;
        src2_tag         = t2;
        src2_value       = (t2 == 0 && op != op_addi) ? b : 32'hdead_beef;
        if (tracked) expect_result(tag, model(op, a, b));
        waited = 0;
        do begin
            @(negedge clock);
            accepted = dispatch_ready;
            @(posedge clock);
            waited++;
        end while (!accepted && waited < 50);
        require(accepted, $sformatf("dispatch of tag %0d was never accepted", tag));
        #2;
        dispatch_valid = 1'b0;
    endtask

    task automatic wait_idle(input int max_cycles);
        int n;
        n = 0;
        do begin
            @(posedge clock);
            n++;
        end while (exp_pending != '0 && n < max_cycles);
        require(exp_pending == '0, $sformatf("tags %b never reached the CDB", exp_pending));
        exp_pending = '0;
        #2;
    endtask

    task automatic probe_ready(input tb_op_e op, input logic expected, input string msg);
        dispatch_inst = encode(op, 12'd0); // Ready must not need dispatch_valid
        @(negedge clock);
        require(dispatch_ready === expected, msg);
        @(posedge clock);
        #2;
    endtask

    // Counts negedges from the dispatch edge to the first CDB cycle
    task automatic single_op(input tb_op_e op, input rob_tag_t tag, input logic [xlen-1:0] a,
                             input logic [xlen-1:0] b, input int latency);
        int n;
        dispatch(op, tag, 0, a, 0, b, 1'b1);
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (!cdb_valid && n < 10);
        compare_value("cdb latency", n, latency);
        compare_value("cdb_rob_tag", cdb_rob_tag, tag);
        @(posedge clock);
        #2;
        wait_idle(10);
    endtask

    // Any tag on the CDB must be outstanding, and appear once
    always @(negedge clock) begin
        if (!reset && cdb_valid) begin
            broadcasts++;
            arrival[cdb_rob_tag] = cycle;
            require(exp_pending[cdb_rob_tag] === 1'b1,
                    $sformatf("CDB broadcast of tag %0d with no result outstanding", cdb_rob_tag));
            if (exp_pending[cdb_rob_tag] === 1'b1) begin
                compare_value($sformatf("cdb_value (tag %0d)", cdb_rob_tag), cdb_value,
                              exp_value[cdb_rob_tag]);
                exp_pending[cdb_rob_tag] = 1'b0;
            end
        end
    end

    task automatic test_single_ops;
        single_op(op_add, 1, 32'd5, 32'd7, 2);
        single_op(op_sub, 2, 32'd3, 32'd10, 2); // Wraps negative
        single_op(op_and, 3, 32'hf0f0_1234, 32'h0ff0_ffff, 2);
        single_op(op_or, 4, 32'h8000_0001, 32'h0000_ff00, 2);
        single_op(op_xor, 5, 32'haaaa_5555, 32'hffff_0000, 2);
        single_op(op_slt, 6, 32'hffff_fffb, 32'd3, 2); // -5 < 3
        single_op(op_slt, 7, 32'd3, 32'hffff_fffb, 2);
        single_op(op_addi, 8, 32'd100, 32'h0000_0ff0, 2); // Immediate -16
        single_op(op_mul, 9, 32'h1234_5678, 32'h9abc_def0, 4);
        single_op(op_mul, 10, 32'hffff_fffd, 32'd7, 4); // -3 * 7
    endtask

    task automatic test_dependency;
        logic [xlen-1:0] a, b, c, prod;
        a    = $random(seed);
        b    = $random(seed);
        c    = $random(seed);
        prod = model(op_mul, a, b);
        dispatch(op_mul, 1, 0, a, 0, b, 1'b1);
        dispatch(op_add, 2, 1, prod, 0, c, 1'b1); // Waits on tag 1
        wait_idle(20);
        require(arrival[2] > arrival[1], "ADD broadcast before the MUL it waits on");
        // Consumer taken at the very edge the producer broadcasts
        prod = model(op_mul, c, b);
        dispatch(op_mul, 3, 0, c, 0, b, 1'b1);
        repeat (3) @(posedge clock);
        #2;
        dispatch(op_sub, 4, 0, a, 3, prod, 1'b1);
        wait_idle(20);
        require(arrival[4] > arrival[3], "SUB broadcast before the MUL it waits on");
    endtask

    task automatic test_class_full;
        logic [xlen-1:0] a, b, prod;
        a    = $random(seed);
        b    = $random(seed);
        prod = model(op_mul, a, b);
        dispatch(op_add, 4, 5, prod, 0, a, 1'b1);
        dispatch(op_xor, 6, 0, b, 5, prod, 1'b1); // Both ALU entries now stuck on tag 5
        probe_ready(op_add, 1'b0, "dispatch_ready high with both ALU entries busy");
        probe_ready(op_mul, 1'b1, "dispatch_ready low for a MUL with free MUL entries");
        dispatch(op_mul, 5, 0, a, 0, b, 1'b1);
        wait_idle(20);
        probe_ready(op_add, 1'b1, "dispatch_ready still low after the ALU entries freed");
    endtask

    task automatic test_contention;
        tb_op_e          seq [8] = '{op_add, op_mul, op_mul, op_slt,
                                     op_or, op_mul, op_sub, op_mul};
        int              start;
        logic [xlen-1:0] a, b;
        start = broadcasts;
        for (int i = 0; i < 8; i++) begin
            a = $random(seed);
            b = $random(seed);
            dispatch(seq[i], rob_tag_t'(i + 1), 0, a, 0, b, 1'b1);
        end
        wait_idle(40);
        compare_value("broadcast count", broadcasts - start, 8);
    endtask

    task automatic test_refusal;
        logic [xlen-1:0] bad [3] = '{32'h0000_2083, 32'h0000_0063, 32'h0031_10b3}; // LW BEQ SLL
        dispatch_valid   = 1'b1;
        dispatch_rob_tag = 4'd15;
        for (int i = 0; i < 3; i++) begin
            dispatch_inst = bad[i];
            for (int k = 0; k < 3; k++) begin
                @(negedge clock);
                require(dispatch_ready === 1'b0,
                        $sformatf("dispatch_ready high for unsupported instruction %h", bad[i]));
            end
            @(posedge clock);
            #2;
        end
        dispatch_valid = 1'b0;
    endtask

    task automatic test_squash;
        int              start;
        logic [xlen-1:0] a, b;
        a = $random(seed);
        b = $random(seed);
        dispatch(op_add, 7, 8, a, 0, b, 1'b0); // Tag 8 never comes
        dispatch(op_mul, 9, 0, a, 8, b, 1'b0);
        dispatch(op_mul, 10, 0, a, 0, b, 1'b0);
        @(posedge clock);
        #2;
        squash = 1'b1; // Tag 10 is in the multiplier by now
        @(posedge clock);
        #2;
        squash = 1'b0;
        start  = broadcasts;
        probe_ready(op_add, 1'b1, "ALU entries still busy after squash");
        probe_ready(op_mul, 1'b1, "MUL entries still busy after squash");
        repeat (8) @(posedge clock);
        #2;
        compare_value("broadcasts after squash", broadcasts - start, 0);
        dispatch(op_add, 7, 0, a, 0, b, 1'b1);
        dispatch(op_mul, 9, 0, b, 0, a, 1'b1);
        wait_idle(20);
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) $display("%s: ok", name);
        else $display("%s: %0d errors", name, errors - errors_before);
    endtask

    initial begin
        #(num_tests * cycles_per_test * clock_period);
        $display("Watchdog expired at cycle %0d, a test hung", cycle);
        $display("Checks failed");
        $finish;
    end

    initial begin
        seed             = 32'h07b7_15ba;
        reset            = 1'b1;
        squash           = 1'b0;
        dispatch_valid   = 1'b0;
        dispatch_inst    = '0;
        dispatch_rob_tag = '0;
        src1_tag         = '0;
        src1_value       = '0;
        src2_tag         = '0;
        src2_value       = '0;
        foreach (arrival[i]) arrival[i] = 0;
        repeat (2) @(posedge clock);
        #2;
        reset = 1'b0;
        mark = errors;
        test_single_ops();
        report_test("single ops and latency", mark);
        mark = errors;
        test_dependency();
        report_test("dependency chain", mark);
        mark = errors;
        test_class_full();
        report_test("class full", mark);
        mark = errors;
        test_contention();
        report_test("CDB contention", mark);
        mark = errors;
        test_refusal();
        report_test("unsupported refusal", mark);
        mark = errors;
        test_squash();
        report_test("squash", mark);
        $display("Summary: %0d checks, %0d errors, %0d CDB broadcasts", checks, errors, broadcasts);
        if (errors == 0) $display("All checks passed");
        else $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
verilog/issue_pkg.sv
verilog/rs_issue_if.sv
verilog/fu_result_if.sv
verilog/inst_decode.sv
verilog/rs.sv
verilog/alu_unit.sv
verilog/mult_pipe.sv
verilog/cdb_arbiter.sv
verilog/issue_core_top.sv
verification/issue_core_tb.sv
